// File: uart_pkg.sv
package uart_pkg;

    // Serial frame is fixed at 8N1
    localparam int DATA_BITS = 8;   // Data bits per frame, LSB first

    // Transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,    // Line parked high
        TX_START = 2'd1,    // Start bit, line low
        TX_DATA  = 2'd2,    // Shifting out data bits
        TX_STOP  = 2'd3     // Stop bit, line high
    } tx_state_t;

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,    // Waiting for a falling edge
        RX_START = 2'd1,    // Half bit wait, then recheck the start bit
        RX_DATA  = 2'd2,    // Sampling data bits at mid-bit
        RX_STOP  = 2'd3     // Sampling the stop bit
    } rx_state_t;

endpackage

// File: bus_pkg.sv
package bus_pkg;

    // Wishbone side widths
    localparam int ADDR_W = 2;      // Word address, four slots
    localparam int DATA_W = 8;      // One byte per access

    // Register map
    typedef enum logic [ADDR_W-1:0] {
        REG_TXDATA = 2'd0,          // Write starts a frame
        REG_RXDATA = 2'd1,          // Read clears valid and overrun
        REG_STATUS = 2'd2           // Read only
    } reg_addr_t;

    // Status register bit positions
    localparam int STAT_TX_BUSY    = 0;
    localparam int STAT_RX_VALID   = 1;
    localparam int STAT_RX_OVERRUN = 2;
    localparam int STAT_FRAME_ERR  = 3;   // Stop bit of last byte was low

endpackage

// File: wb_if.sv
`timescale 1ns/1ps

// Wishbone classic, single slave side, no error or retry
interface wb_if;

    logic [bus_pkg::ADDR_W-1:0] adr;     // Word address
    logic [bus_pkg::DATA_W-1:0] dat_w;   // Master to slave data
    logic [bus_pkg::DATA_W-1:0] dat_r;   // Slave to master data
    logic                       we;      // 1 = write
    logic                       stb;     // Strobe, valid access
    logic                       cyc;     // Bus cycle in progress
    logic                       ack;     // One cycle per access

    // Master holds request fields until ack is seen
    modport master (
        output adr, dat_w, we, stb, cyc,
        input  dat_r, ack
    );

    modport slave (
        input  adr, dat_w, we, stb, cyc,
        output dat_r, ack
    );

endinterface

// File: uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int BAUD      = 115200,
    parameter int CLK_FREQ  = 50_000_000,
    parameter int ACC_WIDTH = 16            // Phase accumulator width
) (
    input  logic                       sourceClk,
    input  logic                       rst_n,
    input  logic                       start,   // Sampled only in idle
    input  logic [bus_pkg::DATA_W-1:0] data,    // Byte to send
    output logic                       line,    // Serial out, idle high
    output logic                       busy,
    output logic                       done     // One cycle at end of stop bit
);

    // Rounded phase step, 64-bit math so fast baud rates do not overflow
    localparam longint INC_L = ((longint'(BAUD) << (ACC_WIDTH - 4))
                               + longint'(CLK_FREQ >> 5)) / longint'(CLK_FREQ >> 4);
    localparam logic [ACC_WIDTH:0] INC      = (ACC_WIDTH + 1)'(INC_L);
    localparam logic [2:0]         LAST_BIT = 3'(uart_pkg::DATA_BITS - 1);

    uart_pkg::tx_state_t        state;
    logic [ACC_WIDTH-1:0]       acc;
    logic [ACC_WIDTH:0]         sum;
    logic                       tick;       // Carry out of the accumulator
    logic [bus_pkg::DATA_W-1:0] shift;
    logic [2:0]                 bit_cnt;

    assign sum  = {1'b0, acc} + INC;
    assign tick = sum[ACC_WIDTH];
    assign busy = (state != uart_pkg::TX_IDLE);  // Falls together with done

    always_ff @(posedge sourceClk) begin
        if (!rst_n) begin
            state   <= uart_pkg::TX_IDLE;
            line    <= 1'b1;
            done    <= 1'b0;
            acc     <= '0;
            bit_cnt <= '0;
        end else begin
            done <= 1'b0;
            acc  <= tick ? '0 : sum[ACC_WIDTH-1:0];  // Restart phase at each bit edge
            case (state)
                uart_pkg::TX_IDLE: begin
                    acc <= '0;
                    if (start) begin
                        state <= uart_pkg::TX_START;
                        line  <= 1'b0;                // Start bit
                    end
                end
                uart_pkg::TX_START: if (tick) begin
                    state   <= uart_pkg::TX_DATA;
                    line    <= shift[0];              // LSB first
                    bit_cnt <= '0;
                end
                uart_pkg::TX_DATA: if (tick) begin
                    if (bit_cnt == LAST_BIT) begin
                        state <= uart_pkg::TX_STOP;
                        line  <= 1'b1;                // Stop bit
                    end else begin
                        line    <= shift[0];
                        bit_cnt <= bit_cnt + 3'd1;
                    end
                end
                uart_pkg::TX_STOP: if (tick) begin
                    state <= uart_pkg::TX_IDLE;
                    done  <= 1'b1;
                end
            endcase
        end
    end

    // Shift register, next bit always at position 0
    always_ff @(posedge sourceClk) begin
        if (state == uart_pkg::TX_IDLE && start)
            shift <= data;
        else if (tick && (state == uart_pkg::TX_START || state == uart_pkg::TX_DATA))
            shift <= shift >> 1;
    end

endmodule

// File: uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter int BAUD      = 115200,
    parameter int CLK_FREQ  = 50_000_000,
    parameter int ACC_WIDTH = 16
) (
    input  logic                       sourceClk,
    input  logic                       rst_n,
    input  logic                       line,       // Async serial in
    output logic [bus_pkg::DATA_W-1:0] data,       // Stable while idle after valid
    output logic                       valid,      // One cycle after stop sample
    output logic                       frame_err   // Stop bit was low
);

    // Same rounded phase step as the transmitter
    localparam longint INC_L = ((longint'(BAUD) << (ACC_WIDTH - 4))
                               + longint'(CLK_FREQ >> 5)) / longint'(CLK_FREQ >> 4);
    localparam logic [ACC_WIDTH:0] INC      = (ACC_WIDTH + 1)'(INC_L);
    localparam logic [ACC_WIDTH:0] INC2     = INC << 1;   // Half bit in start state
    localparam logic [2:0]         LAST_BIT = 3'(uart_pkg::DATA_BITS - 1);

    uart_pkg::rx_state_t        state;
    logic                       line_meta;  // First sync stage
    logic                       line_sync;
    logic                       line_prev;  // For edge detect
    logic [ACC_WIDTH-1:0]       acc;
    logic [ACC_WIDTH:0]         step;
    logic [ACC_WIDTH:0]         sum;
    logic                       tick;
    logic [bus_pkg::DATA_W-1:0] shift;
    logic [2:0]                 bit_cnt;

    assign step = (state == uart_pkg::RX_START) ? INC2 : INC;
    assign sum  = {1'b0, acc} + step;
    assign tick = sum[ACC_WIDTH];
    assign data = shift;

    always_ff @(posedge sourceClk) begin
        if (!rst_n) begin
            state     <= uart_pkg::RX_IDLE;
            line_meta <= 1'b1;              // Idle level, no false edge out of reset
            line_sync <= 1'b1;
            line_prev <= 1'b1;
            acc       <= '0;
            bit_cnt   <= '0;
            valid     <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            line_meta <= line;
            line_sync <= line_meta;
            line_prev <= line_sync;
            valid     <= 1'b0;
            acc       <= tick ? '0 : sum[ACC_WIDTH-1:0];
            case (state)
                uart_pkg::RX_IDLE: begin
                    acc <= '0;
                    if (line_prev && !line_sync)   // Falling edge, start bit begins
                        state <= uart_pkg::RX_START;
                end
                uart_pkg::RX_START: if (tick) begin
                    // Mid start bit, a high line means a glitch
                    if (!line_sync) begin
                        state   <= uart_pkg::RX_DATA;
                        bit_cnt <= '0;
                    end else begin
                        state <= uart_pkg::RX_IDLE;
                    end
                end
                uart_pkg::RX_DATA: if (tick) begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == LAST_BIT)
                        state <= uart_pkg::RX_STOP;
                end
                uart_pkg::RX_STOP: if (tick) begin
                    state     <= uart_pkg::RX_IDLE;
                    valid     <= 1'b1;
                    frame_err <= !line_sync;      // Stop bit must be high
                end
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge sourceClk) begin
        if (state == uart_pkg::RX_DATA && tick)
            shift <= {line_sync, shift[bus_pkg::DATA_W-1:1]};
    end

endmodule

// File: uart_regs.sv
`timescale 1ns/1ps

module uart_regs #(
    parameter int BAUD      = 115200,
    parameter int CLK_FREQ  = 50_000_000,
    parameter int ACC_WIDTH = 16
) (
    input  logic sourceClk,
    input  logic rst_n,
    wb_if.slave  bus,
    output logic tx_line,
    input  logic rx_line
);

    bus_pkg::reg_addr_t         addr;
    logic                       req;        // New access, not yet acked
    logic                       tx_wr;
    logic                       accept;     // Access completes, ack next cycle
    logic                       rd_rx;
    logic                       tx_start;
    logic                       tx_busy;
    logic [bus_pkg::DATA_W-1:0] rx_byte;
    logic                       rx_pulse;
    logic                       rx_ferr;
    logic [bus_pkg::DATA_W-1:0] rx_data;    // Holding register, one byte deep
    logic                       rx_valid;
    logic                       rx_overrun;
    logic                       frame_err;
    logic [bus_pkg::DATA_W-1:0] status;
    logic [bus_pkg::DATA_W-1:0] rd_mux;

    assign addr  = bus_pkg::reg_addr_t'(bus.adr);
    assign req   = bus.cyc && bus.stb && !bus.ack;
    assign tx_wr = req && bus.we && (addr == bus_pkg::REG_TXDATA);

    // TXDATA write waits for the transmitter, everything else goes straight through
    assign accept   = req && !(tx_wr && tx_busy);
    assign tx_start = tx_wr && !tx_busy;
    assign rd_rx    = accept && !bus.we && (addr == bus_pkg::REG_RXDATA);

    always_comb begin
        status                           = '0;
        status[bus_pkg::STAT_TX_BUSY]    = tx_busy;
        status[bus_pkg::STAT_RX_VALID]   = rx_valid;
        status[bus_pkg::STAT_RX_OVERRUN] = rx_overrun;
        status[bus_pkg::STAT_FRAME_ERR]  = frame_err;
        case (addr)
            bus_pkg::REG_RXDATA: rd_mux = rx_data;
            bus_pkg::REG_STATUS: rd_mux = status;
            default:             rd_mux = '0;    // TXDATA and the spare slot read 0
        endcase
    end

    always_ff @(posedge sourceClk) begin
        if (!rst_n) bus.ack <= 1'b0;
        else        bus.ack <= accept;           // Single cycle, req is masked by ack
    end

    always_ff @(posedge sourceClk) begin
        if (accept && !bus.we) bus.dat_r <= rd_mux;  // Captured before read-clear
    end

    // RX holding state, a new byte wins over a same-cycle read
    always_ff @(posedge sourceClk) begin
        if (!rst_n) begin
            rx_valid   <= 1'b0;
            rx_overrun <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            if (rd_rx) begin
                rx_valid   <= 1'b0;
                rx_overrun <= 1'b0;
            end
            if (rx_pulse) begin
                rx_valid  <= 1'b1;
                frame_err <= rx_ferr;
                if (rx_valid && !rd_rx) rx_overrun <= 1'b1;  // Previous byte lost
            end
        end
    end

    always_ff @(posedge sourceClk) begin
        if (rx_pulse) rx_data <= rx_byte;
    end

    uart_tx #(.BAUD(BAUD), .CLK_FREQ(CLK_FREQ), .ACC_WIDTH(ACC_WIDTH)) i_uart_tx (
        .sourceClk, .rst_n,
        .start (tx_start),
        .data  (bus.dat_w),
        .line  (tx_line),
        .busy  (tx_busy),
        .done  ()                                // busy already marks frame end
    );

    uart_rx #(.BAUD(BAUD), .CLK_FREQ(CLK_FREQ), .ACC_WIDTH(ACC_WIDTH)) i_uart_rx (
        .sourceClk, .rst_n,
        .line      (rx_line),
        .data      (rx_byte),
        .valid     (rx_pulse),
        .frame_err (rx_ferr)
    );

endmodule

// File: wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter (
    input  logic sourceClk,
    input  logic rst_n,
    wb_if.slave  m_a,       // Port a master
    wb_if.slave  m_b,       // Port b master
    wb_if.master s          // Shared slave
);

    typedef enum logic {
        ARB_IDLE = 1'b0,    // Nobody owns the bus
        ARB_BUSY = 1'b1     // last_b names the owner
    } arb_state_t;

    arb_state_t state;
    logic       last_b;     // 1 = b granted last, also current owner when busy
    logic       pick_b;
    logic       own_cyc;
    logic       gnt_a;
    logic       gnt_b;

    // Round robin, the master not served last wins a tie
    assign pick_b  = m_b.cyc && (!m_a.cyc || !last_b);
    assign own_cyc = last_b ? m_b.cyc : m_a.cyc;
    assign gnt_a   = (state == ARB_BUSY) && !last_b;
    assign gnt_b   = (state == ARB_BUSY) && last_b;

    always_ff @(posedge sourceClk) begin
        if (!rst_n) begin
            state  <= ARB_IDLE;
            last_b <= 1'b1;                 // Port a first after reset
        end else if (state == ARB_IDLE) begin
            if (m_a.cyc || m_b.cyc) begin
                state  <= ARB_BUSY;
                last_b <= pick_b;
            end
        end else if (!own_cyc) begin
            state <= ARB_IDLE;              // Owner ended its cycle
        end
    end

    // Request path from the owner only
    assign s.cyc   = gnt_a ? m_a.cyc   : gnt_b ? m_b.cyc : 1'b0;
    assign s.stb   = gnt_a ? m_a.stb   : gnt_b ? m_b.stb : 1'b0;
    assign s.we    = last_b ? m_b.we    : m_a.we;
    assign s.adr   = last_b ? m_b.adr   : m_a.adr;
    assign s.dat_w = last_b ? m_b.dat_w : m_a.dat_w;

    // Response path, the waiting master sees nothing
    assign m_a.ack   = gnt_a && s.ack;
    assign m_b.ack   = gnt_b && s.ack;
    assign m_a.dat_r = gnt_a ? s.dat_r : '0;
    assign m_b.dat_r = gnt_b ? s.dat_r : '0;

endmodule

// File: uart_top.sv
`timescale 1ns/1ps

module uart_top #(
    parameter int BAUD      = 115200,
    parameter int CLK_FREQ  = 50_000_000,
    parameter int ACC_WIDTH = 16
) (
    input  logic                       sourceClk,
    input  logic                       rst_n,
    // Wishbone master a
    input  logic [bus_pkg::ADDR_W-1:0] a_adr,
    input  logic [bus_pkg::DATA_W-1:0] a_dat_w,
    input  logic                       a_we,
    input  logic                       a_stb,
    input  logic                       a_cyc,
    output logic [bus_pkg::DATA_W-1:0] a_dat_r,
    output logic                       a_ack,
    // Wishbone master b
    input  logic [bus_pkg::ADDR_W-1:0] b_adr,
    input  logic [bus_pkg::DATA_W-1:0] b_dat_w,
    input  logic                       b_we,
    input  logic                       b_stb,
    input  logic                       b_cyc,
    output logic [bus_pkg::DATA_W-1:0] b_dat_r,
    output logic                       b_ack,
    // Serial lines
    output logic                       tx_line,
    input  logic                       rx_line
);

    wb_if m_a ();
    wb_if m_b ();
    wb_if s_bus ();         // Arbiter to register block

    assign m_a.adr   = a_adr;
    assign m_a.dat_w = a_dat_w;
    assign m_a.we    = a_we;
    assign m_a.stb   = a_stb;
    assign m_a.cyc   = a_cyc;
    assign a_dat_r   = m_a.dat_r;
    assign a_ack     = m_a.ack;

    assign m_b.adr   = b_adr;
    assign m_b.dat_w = b_dat_w;
    assign m_b.we    = b_we;
    assign m_b.stb   = b_stb;
    assign m_b.cyc   = b_cyc;
    assign b_dat_r   = m_b.dat_r;
    assign b_ack     = m_b.ack;

    wb_arbiter i_wb_arbiter (
        .sourceClk, .rst_n,
        .m_a (m_a.slave),
        .m_b (m_b.slave),
        .s   (s_bus.master)
    );

    uart_regs #(.BAUD(BAUD), .CLK_FREQ(CLK_FREQ), .ACC_WIDTH(ACC_WIDTH)) i_uart_regs (
        .sourceClk, .rst_n,
        .bus     (s_bus.slave),
        .tx_line (tx_line),
        .rx_line (rx_line)
    );

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic sourceClk,
    output logic rst_n
);

    initial begin
        sourceClk = 1'b0;
        forever #(PERIOD_NS / 2) sourceClk = ~sourceClk;
    end

    // Release lands just after an edge, like the rest of the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge sourceClk);
        #2 rst_n = 1'b1;
    end

endmodule

// File: uart_top_properties.sv
`timescale 1ns/1ps

module uart_top_properties (
    input logic sourceClk,
    input logic rst_n,
    input logic a_stb,
    input logic a_cyc,
    input logic a_ack,
    input logic b_stb,
    input logic b_cyc,
    input logic b_ack,
    input logic tx_line,
    input logic tx_busy     // Transmitter state inside uart_regs
);

    int fail_count = 0;     // Watched from the testbench top

    // A slave answers only a live request
    a_ack_in_cycle: assert property (@(posedge sourceClk) disable iff (!rst_n)
        a_ack |-> (a_stb && a_cyc))
        else begin
            fail_count = fail_count + 1;
            $error("a_ack high without a_stb and a_cyc");
        end

    b_ack_in_cycle: assert property (@(posedge sourceClk) disable iff (!rst_n)
        b_ack |-> (b_stb && b_cyc))
        else begin
            fail_count = fail_count + 1;
            $error("b_ack high without b_stb and b_cyc");
        end

    // Only the owner of the shared slave ever sees ack
    one_ack: assert property (@(posedge sourceClk) disable iff (!rst_n) !(a_ack && b_ack))
        else begin
            fail_count = fail_count + 1;
            $error("a_ack and b_ack high together");
        end

    // Idle line parks high
    line_idle: assert property (@(posedge sourceClk) disable iff (!rst_n) !tx_busy |-> tx_line)
        else begin
            fail_count = fail_count + 1;
            $error("tx_line low while the transmitter is idle");
        end

endmodule

bind uart_top uart_top_properties i_uart_top_properties (
    .sourceClk, .rst_n, .a_stb, .a_cyc, .a_ack, .b_stb, .b_cyc, .b_ack, .tx_line,
    .tx_busy (i_uart_regs.tx_busy)
);

// File: tb_uart_top.sv
`timescale 1ns/1ps

module tb_uart_top;

    localparam int CLK_FREQ    = 50_000_000;
    localparam int BAUD        = 3_125_000;       // 16 clocks per bit
    localparam int ACC_WIDTH   = 16;
    localparam int FRAME_CYC   = (uart_pkg::DATA_BITS + 2) * (CLK_FREQ / BAUD);
    localparam int ACK_TIMEOUT = 400;             // Cycles per access
    localparam int POLL_LIMIT  = 100;             // Status reads per poll

    logic                       sourceClk;
    logic                       rst_n;
    logic [bus_pkg::ADDR_W-1:0] wb_adr   [2];     // Index 0 is port a, 1 is port b
    logic [bus_pkg::DATA_W-1:0] wb_dat_w [2];
    logic [bus_pkg::DATA_W-1:0] wb_dat_r [2];
    logic                       wb_we    [2];
    logic                       wb_stb   [2];
    logic                       wb_cyc   [2];
    logic                       wb_ack   [2];
    logic                       serial;           // tx_line looped back to rx_line
    logic [31:0]                lfsr = 32'h135;
    int                         cycle = 0;
    int                         ack_at [2];       // Cycle of the latest ack per port
    int                         ack_count [2] = '{0, 0};
    int                         last_port = 1;    // Round robin model, a wins the first tie

    tb_clock i_tb_clock (.sourceClk, .rst_n);

    uart_top #(.BAUD(BAUD), .CLK_FREQ(CLK_FREQ), .ACC_WIDTH(ACC_WIDTH)) i_uart_top (
        .sourceClk, .rst_n,
        .a_adr   (wb_adr[0]),   .b_adr   (wb_adr[1]),
        .a_dat_w (wb_dat_w[0]), .b_dat_w (wb_dat_w[1]),
        .a_we    (wb_we[0]),    .b_we    (wb_we[1]),
        .a_stb   (wb_stb[0]),   .b_stb   (wb_stb[1]),
        .a_cyc   (wb_cyc[0]),   .b_cyc   (wb_cyc[1]),
        .a_dat_r (wb_dat_r[0]), .b_dat_r (wb_dat_r[1]),
        .a_ack   (wb_ack[0]),   .b_ack   (wb_ack[1]),
        .tx_line (serial),
        .rx_line (serial)
    );

    always @(posedge sourceClk) cycle <= cycle + 1;

    always @(negedge sourceClk) begin
        if (wb_ack[0]) ack_count[0] += 1;
        if (wb_ack[1]) ack_count[1] += 1;
        if (i_uart_top.i_uart_top_properties.fail_count != 0)
            stop_with_failure("a bound bus or serial line property failed");
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_eq(input string name, input int got, input int exp);
        assert (got == exp) else
            stop_with_failure($sformatf("mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
                                        $time, name, got, exp));
    endtask

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [7:0] rand_byte();
        logic       fb;
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            b    = {b[6:0], fb};
        end
        return b;
    endfunction

    // One classic cycle, request held until ack
    task automatic bus_cycle(input int port, input logic [bus_pkg::ADDR_W-1:0] adr,
                             input logic we, input logic [7:0] wdata, output logic [7:0] rdata);
        int waited;
        waited = 0;
        @(posedge sourceClk);
        #2;
        wb_adr[port]   = adr;
        wb_dat_w[port] = wdata;
        wb_we[port]    = we;
        wb_stb[port]   = 1'b1;
        wb_cyc[port]   = 1'b1;
        do begin
            @(negedge sourceClk);                 // ack and dat_r are stable here
            waited++;
            if (waited > ACK_TIMEOUT)
                stop_with_failure($sformatf("no ack on port %s within %0d cycles",
                                            port ? "b" : "a", ACK_TIMEOUT));
        end while (!wb_ack[port]);
        rdata        = wb_dat_r[port];
        ack_at[port] = cycle;
        last_port    = port;
        @(posedge sourceClk);
        #2;
        wb_stb[port] = 1'b0;
        wb_cyc[port] = 1'b0;
        wb_we[port]  = 1'b0;
    endtask

    task automatic wb_write_a(input logic [bus_pkg::ADDR_W-1:0] adr, input logic [7:0] data);
        logic [7:0] ignored;
        bus_cycle(0, adr, 1'b1, data, ignored);
    endtask

    task automatic wb_write_b(input logic [bus_pkg::ADDR_W-1:0] adr, input logic [7:0] data);
        logic [7:0] ignored;
        bus_cycle(1, adr, 1'b1, data, ignored);
    endtask

    task automatic wb_read_a(input logic [bus_pkg::ADDR_W-1:0] adr, output logic [7:0] data);
        bus_cycle(0, adr, 1'b0, 8'h00, data);
    endtask

    task automatic wb_read_b(input logic [bus_pkg::ADDR_W-1:0] adr, output logic [7:0] data);
        bus_cycle(1, adr, 1'b0, 8'h00, data);
    endtask

    // Status reads on port a until one bit reaches the wanted level
    task automatic poll_status(input int pos, input logic want, output logic [7:0] st);
        int tries;
        tries = 0;
        do begin
            wb_read_a(bus_pkg::REG_STATUS, st);
            check_eq("a_dat_r frame error bit", int'(st[bus_pkg::STAT_FRAME_ERR]), 0);
            tries++;
            if (tries > POLL_LIMIT)
                stop_with_failure($sformatf("status bit %0d never became %0b", pos, want));
        end while (st[pos] != want);
    endtask

    initial begin
        logic [7:0] st;
        logic [7:0] st_b;
        logic [7:0] rd;
        logic [7:0] tx_byte [2];
        int         first;
        int         acks_before [2];
        int         t0;
        int         waited;
        for (int p = 0; p < 2; p++) begin
            wb_adr[p]   = '0;
            wb_dat_w[p] = '0;
            wb_we[p]    = 1'b0;
            wb_stb[p]   = 1'b0;
            wb_cyc[p]   = 1'b0;
        end
        waited = 0;
        while (rst_n !== 1'b1) begin
            @(posedge sourceClk);
            waited++;
            if (waited > 50) stop_with_failure("reset was never released");
        end

        // Quiet state out of reset
        check_eq("tx_line", int'(serial), 1);
        wb_read_a(bus_pkg::REG_STATUS, st);
        check_eq("a_dat_r", int'(st), 0);

        // Single byte through the loopback
        tx_byte[0] = rand_byte();
        wb_write_a(bus_pkg::REG_TXDATA, tx_byte[0]);
        poll_status(bus_pkg::STAT_RX_VALID, 1'b1, st);
        wb_read_a(bus_pkg::REG_RXDATA, rd);
        check_eq("a_dat_r", int'(rd), int'(tx_byte[0]));
        wb_read_a(bus_pkg::REG_STATUS, st);
        check_eq("a_dat_r valid bit", int'(st[bus_pkg::STAT_RX_VALID]), 0);
        check_eq("a_dat_r overrun bit", int'(st[bus_pkg::STAT_RX_OVERRUN]), 0);

        // Both masters at once, the one not served last goes first
        tx_byte[0]  = rand_byte();
        tx_byte[1]  = rand_byte();
        first       = 1 - last_port;
        acks_before = ack_count;
        fork
            wb_write_a(bus_pkg::REG_TXDATA, tx_byte[0]);
            wb_write_b(bus_pkg::REG_TXDATA, tx_byte[1]);
        join
        check_eq("a_ack count", ack_count[0] - acks_before[0], 1);
        check_eq("b_ack count", ack_count[1] - acks_before[1], 1);
        check_eq("first acked port", (ack_at[0] < ack_at[1]) ? 0 : 1, first);
        poll_status(bus_pkg::STAT_RX_OVERRUN, 1'b1, st);   // Second byte landed on the first
        check_eq("a_dat_r valid bit", int'(st[bus_pkg::STAT_RX_VALID]), 1);
        wb_read_a(bus_pkg::REG_RXDATA, rd);
        check_eq("a_dat_r", int'(rd), int'(tx_byte[1 - first]));

        // Write while busy stalls, port b waits behind it
        poll_status(bus_pkg::STAT_TX_BUSY, 1'b0, st);
        tx_byte[0] = rand_byte();
        tx_byte[1] = rand_byte();
        wb_write_a(bus_pkg::REG_TXDATA, tx_byte[0]);
        t0 = ack_at[0];
        fork
            wb_write_a(bus_pkg::REG_TXDATA, tx_byte[1]);
            begin
                repeat (20) @(posedge sourceClk);
                wb_read_b(bus_pkg::REG_STATUS, st_b);
            end
        join
        assert (ack_at[0] - t0 >= FRAME_CYC) else
            stop_with_failure($sformatf("stalled TXDATA write acked after %0d cycles, frame is %0d",
                                        ack_at[0] - t0, FRAME_CYC));
        assert (ack_at[1] > ack_at[0]) else
            stop_with_failure("port b finished its read while port a still held the bus");
        check_eq("b_dat_r busy bit", int'(st_b[bus_pkg::STAT_TX_BUSY]), 1);
        poll_status(bus_pkg::STAT_RX_OVERRUN, 1'b1, st);
        wb_read_a(bus_pkg::REG_RXDATA, rd);
        check_eq("a_dat_r", int'(rd), int'(tx_byte[1]));

        // Random bytes one at a time
        for (int i = 0; i < 12; i++) begin
            tx_byte[0] = rand_byte();
            wb_write_a(bus_pkg::REG_TXDATA, tx_byte[0]);
            poll_status(bus_pkg::STAT_RX_VALID, 1'b1, st);
            wb_read_a(bus_pkg::REG_RXDATA, rd);
            check_eq("a_dat_r", int'(rd), int'(tx_byte[0]));
        end

        if (i_uart_top.i_uart_top_properties.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            stop_with_failure("a bound bus or serial line property failed");
        end
    end

endmodule

// File: verilog.f
uart_pkg.sv
bus_pkg.sv
wb_if.sv
uart_tx.sv
uart_rx.sv
uart_regs.sv
wb_arbiter.sv
uart_top.sv
tb_clock.sv
uart_top_properties.sv
tb_uart_top.sv

// File: Makefile
SIM := obj_dir/Vtb_uart_top

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): verilog.f $(wildcard *.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_uart_top -f verilog.f

# Pass only when the pass message shows up in the output
run: $(SIM)
	@out="$$(./$(SIM) +verilator+error+limit+100)"; echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
